//--- logic/demod_params.svh
`ifndef DEMOD_PARAMS_SVH
`define DEMOD_PARAMS_SVH

// transform size, every twiddle is a power of j
`define DEMOD_FFT_LEN 4

// window starts this many samples early inside the CP
`define DEMOD_CP_ADVANCE 1

// real and imaginary part widths
`define DEMOD_IN_W 8
`define DEMOD_OUT_W 10 // input width plus 2 growth bits of the 4-point sum

// symbol credits held downstream after reset
`define DEMOD_CREDITS 2

// one metadata entry per DFT buffer
`define DEMOD_META_DEPTH 2

`endif

//--- logic/frame_pkg.sv
package frame_pkg;

    typedef logic [9:0] sfn_t;      // system frame number
    typedef logic [4:0] subframe_t;
    typedef logic [3:0] symbol_t;   // symbol within the subframe
    typedef logic [1:0] cp_len_t;   // 2 or 3 samples

    // frame position of one OFDM symbol
    typedef struct packed {
        sfn_t      sfn;
        subframe_t subframe;
        symbol_t   symbol;
    } sym_meta_t;

    // user field on every input sample
    typedef struct packed {
        sym_meta_t meta;
        cp_len_t   cp_len;
    } in_user_t;

endpackage

//--- logic/demod_pkg.sv
`include "demod_params.svh"

package demod_pkg;

    typedef logic signed [`DEMOD_IN_W-1:0]  iq_in_t;  // one part of a time sample
    typedef logic signed [`DEMOD_OUT_W-1:0] iq_out_t; // one part of a frequency bin
    typedef logic [$clog2(`DEMOD_FFT_LEN)-1:0] bin_idx_t;

    typedef struct packed {
        iq_in_t im;
        iq_in_t re;
    } sample_t;

    typedef struct packed {
        iq_out_t im;
        iq_out_t re;
    } bin_t;

    // one window sample from the cp_remover to the DFT
    typedef struct packed {
        sample_t              sample;
        logic                 first;
        logic                 last;
        frame_pkg::sym_meta_t meta;
    } win_beat_t;

    typedef struct packed {
        bin_t                 bin;
        logic                 last; // set on bin 3
        frame_pkg::sym_meta_t meta;
    } out_beat_t;

endpackage

//--- logic/cp_remover.sv
`timescale 1ns/1ps
`include "demod_params.svh"

module cp_remover (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 in_valid_i,
    input  demod_pkg::sample_t   in_data_i,
    input  frame_pkg::in_user_t  in_user_i,
    input  logic                 in_last_i,
    input  logic                 ssb_start_i,
    output logic                 win_valid_o,
    output demod_pkg::win_beat_t win_beat_o
);

    localparam int WIN_CNT_W = $clog2(`DEMOD_FFT_LEN) + 1;
    localparam logic [WIN_CNT_W-1:0] WIN_LAST = WIN_CNT_W'(`DEMOD_FFT_LEN - 1);

    typedef enum logic [1:0] {
        skip_cp,
        take_window,
        skip_tail
    } state_t;

    state_t               state_q;
    frame_pkg::cp_len_t   cp_cnt_q;  // CP samples seen so far
    frame_pkg::cp_len_t   cp_len_q;
    frame_pkg::sym_meta_t meta_q;
    logic [WIN_CNT_W-1:0] win_cnt_q;

    logic                 cp_take;   // sample counts as CP
    logic                 cp_first;  // sample opens a new symbol
    frame_pkg::cp_len_t   cp_cnt_eff;
    frame_pkg::cp_len_t   skip_len;

    // ssb_start in the tail turns this sample into CP sample 1
    assign cp_take = in_valid_i &&
                     (state_q == skip_cp || (state_q == skip_tail && ssb_start_i));
    assign cp_first   = cp_take && (ssb_start_i || cp_cnt_q == '0);
    assign cp_cnt_eff = cp_first ? '0 : cp_cnt_q;
    assign skip_len   = (cp_first ? in_user_i.cp_len : cp_len_q)
                      - frame_pkg::cp_len_t'(`DEMOD_CP_ADVANCE);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= skip_cp;
            cp_cnt_q  <= '0;
            win_cnt_q <= '0;
        end else begin
            case (state_q)
                skip_cp, skip_tail: begin
                    if (cp_take) begin
                        if (cp_cnt_eff + 1'b1 == skip_len) begin
                            state_q  <= take_window;
                            cp_cnt_q <= '0;
                        end else begin
                            state_q  <= skip_cp;
                            cp_cnt_q <= cp_cnt_eff + 1'b1;
                        end
                    end else if (state_q == skip_tail && in_valid_i && in_last_i) begin
                        state_q <= skip_cp;
                    end
                end
                take_window: begin
                    if (in_valid_i) begin
                        if (win_cnt_q == WIN_LAST) begin
                            win_cnt_q <= '0;
                            state_q   <= in_last_i ? skip_cp : skip_tail; // no tail left
                        end else begin
                            win_cnt_q <= win_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= skip_cp;
            endcase
        end
    end

    // frame info comes with the first CP sample
    always_ff @(posedge clk_i) begin
        if (cp_first) begin
            meta_q   <= in_user_i.meta;
            cp_len_q <= in_user_i.cp_len;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= in_valid_i && state_q == take_window;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && state_q == take_window) begin
            win_beat_o.sample <= in_data_i;
            win_beat_o.first  <= win_cnt_q == '0;
            win_beat_o.last   <= win_cnt_q == WIN_LAST;
            win_beat_o.meta   <= meta_q;
        end
    end

    a_win_cnt_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        win_cnt_q <= WIN_LAST);

endmodule

//--- logic/meta_fifo.sv
`timescale 1ns/1ps

module meta_fifo #(
    parameter int DEPTH = 2 // power of two
) (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 push_i,
    input  frame_pkg::sym_meta_t push_data_i,
    input  logic                 pop_i,
    output frame_pkg::sym_meta_t head_o,
    output logic                 empty_o
);

    localparam int AW = $clog2(DEPTH);

    frame_pkg::sym_meta_t mem_q [DEPTH];
    logic [AW:0]          wr_ptr_q;   // msb tells a full ring from an empty one
    logic [AW:0]          rd_ptr_q;
    logic                 full;

    assign empty_o = wr_ptr_q == rd_ptr_q;
    assign full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign head_o  = mem_q[rd_ptr_q[AW-1:0]];

    always_ff @(posedge clk_i) begin
        if (push_i) mem_q[wr_ptr_q[AW-1:0]] <= push_data_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        !(push_i && full));
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!reset_ni)
        pop_i |-> !empty_o);

endmodule

//--- logic/block_dft4.sv
`timescale 1ns/1ps
`include "demod_params.svh"

module block_dft4 (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 win_valid_i,
    input  demod_pkg::win_beat_t win_beat_i,
    input  logic                 credit_i,
    output logic                 meta_push_o,
    output frame_pkg::sym_meta_t meta_o,
    output logic                 bin_valid_o,
    output demod_pkg::bin_t      bin_o,
    output demod_pkg::bin_idx_t  bin_idx_o,
    output logic                 overflow_o
);

    localparam int N = `DEMOD_FFT_LEN;
    localparam int CRED_W = $clog2(`DEMOD_CREDITS + 1);

    demod_pkg::sample_t  fill_q [N-1];     // last sample goes straight to a buffer
    demod_pkg::sample_t  buf_q [2][N];     // ping-pong symbol buffers
    demod_pkg::bin_idx_t fill_cnt_q;
    demod_pkg::bin_idx_t fill_idx;
    logic [1:0]          buf_full_q;
    logic                wr_ptr_q;
    logic                rd_ptr_q;
    logic                busy_q;           // bins of rd buffer on the way out
    demod_pkg::bin_idx_t out_idx_q;
    logic [CRED_W-1:0]   credit_q;
    logic                sym_done;
    logic                accept;
    logic                start;

    // multiply x by (-j)^m
    function automatic demod_pkg::bin_t twiddle(demod_pkg::sample_t x, logic [1:0] m);
        demod_pkg::iq_out_t xr;
        demod_pkg::iq_out_t xi;
        demod_pkg::bin_t    y;
        xr = x.re;
        xi = x.im;
        case (m)
            2'd0:    y = '{re: xr, im: xi};
            2'd1:    y = '{re: xi, im: -xr};
            2'd2:    y = '{re: -xr, im: -xi};
            default: y = '{re: -xi, im: xr};
        endcase
        return y;
    endfunction

    assign fill_idx = win_beat_i.first ? '0 : fill_cnt_q;
    assign sym_done = win_valid_i && win_beat_i.last;
    assign accept   = sym_done && !buf_full_q[wr_ptr_q];  // in order, so full here means both
    assign start    = !busy_q && buf_full_q[rd_ptr_q] && credit_q != '0;

    always_ff @(posedge clk_i) begin
        if (win_valid_i && !win_beat_i.last) fill_q[fill_idx] <= win_beat_i.sample;
        if (accept) begin
            for (int n = 0; n < N - 1; n++) begin
                buf_q[wr_ptr_q][n] <= fill_q[n];
            end
            buf_q[wr_ptr_q][N-1] <= win_beat_i.sample;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fill_cnt_q <= '0;
            buf_full_q <= '0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            busy_q     <= 1'b0;
            out_idx_q  <= '0;
            credit_q   <= CRED_W'(`DEMOD_CREDITS);
            overflow_o <= 1'b0;
        end else begin
            if (win_valid_i) fill_cnt_q <= fill_idx + 1'b1;
            if (accept) begin
                buf_full_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q             <= !wr_ptr_q;
            end
            if (sym_done && buf_full_q[wr_ptr_q]) overflow_o <= 1'b1; // symbol dropped
            if (start) begin
                busy_q    <= 1'b1;
                out_idx_q <= '0;
            end else if (busy_q) begin
                out_idx_q <= out_idx_q + 1'b1;
                if (out_idx_q == demod_pkg::bin_idx_t'(N - 1)) begin
                    busy_q               <= 1'b0;
                    buf_full_q[rd_ptr_q] <= 1'b0;
                    rd_ptr_q             <= !rd_ptr_q;
                end
            end
            credit_q <= credit_q + CRED_W'(credit_i) - CRED_W'(start);
        end
    end

    // X_k = sum of x_n * (-j)^(n*k)
    always_comb begin
        demod_pkg::bin_t term;
        bin_o = '0;
        for (int n = 0; n < N; n++) begin
            term     = twiddle(buf_q[rd_ptr_q][n], 2'(n * out_idx_q));
            bin_o.re = bin_o.re + term.re;
            bin_o.im = bin_o.im + term.im;
        end
    end

    assign bin_valid_o = busy_q;
    assign bin_idx_o   = out_idx_q;
    assign meta_push_o = accept;
    assign meta_o      = win_beat_i.meta;

    // downstream never returns more credits than it was given
    a_credit_max: assert property (@(posedge clk_i) disable iff (!reset_ni)
        credit_q <= CRED_W'(`DEMOD_CREDITS));

endmodule

//--- logic/phase_rotator.sv
`timescale 1ns/1ps
`include "demod_params.svh"

module phase_rotator (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 bin_valid_i,
    input  demod_pkg::bin_t      bin_i,
    input  demod_pkg::bin_idx_t  bin_idx_i,
    input  frame_pkg::sym_meta_t meta_head_i,
    output logic                 meta_pop_o,
    output logic                 out_valid_o,
    output demod_pkg::out_beat_t out_beat_o
);

    logic [1:0]      rot;     // power of j for this bin
    demod_pkg::bin_t rotated;
    logic            last_bin;

    assign rot      = 2'(`DEMOD_CP_ADVANCE * bin_idx_i);
    assign last_bin = bin_idx_i == demod_pkg::bin_idx_t'(`DEMOD_FFT_LEN - 1);

    // undo the ramp of the early window, times j^rot
    always_comb begin
        case (rot)
            2'd0:    rotated = bin_i;
            2'd1:    rotated = '{re: -bin_i.im, im: bin_i.re};
            2'd2:    rotated = '{re: -bin_i.re, im: -bin_i.im};
            default: rotated = '{re: bin_i.im, im: -bin_i.re};
        endcase
    end

    assign meta_pop_o = bin_valid_i && last_bin; // head stays valid for the whole symbol

    always_ff @(posedge clk_i) begin
        if (!reset_ni) out_valid_o <= 1'b0;
        else           out_valid_o <= bin_valid_i;
    end

    always_ff @(posedge clk_i) begin
        out_beat_o.bin  <= rotated;
        out_beat_o.last <= last_bin;
        out_beat_o.meta <= meta_head_i;
    end

endmodule

//--- logic/ofdm_demod.sv
`timescale 1ns/1ps
`include "demod_params.svh"

module ofdm_demod (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 in_valid_i,
    input  demod_pkg::sample_t   in_data_i,
    input  frame_pkg::in_user_t  in_user_i,
    input  logic                 in_last_i,
    input  logic                 ssb_start_i,
    input  logic                 credit_i,
    output logic                 out_valid_o,
    output demod_pkg::out_beat_t out_beat_o,
    output logic                 overflow_o
);

    logic                 win_valid;
    demod_pkg::win_beat_t win_beat;
    logic                 meta_push;
    frame_pkg::sym_meta_t meta_in;
    frame_pkg::sym_meta_t meta_head;
    logic                 meta_pop;
    logic                 meta_empty;
    logic                 bin_valid;
    demod_pkg::bin_t      bin;
    demod_pkg::bin_idx_t  bin_idx;

    cp_remover u_cp_remover (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_user_i   (in_user_i),
        .in_last_i   (in_last_i),
        .ssb_start_i (ssb_start_i),
        .win_valid_o (win_valid),
        .win_beat_o  (win_beat)
    );

    block_dft4 u_block_dft4 (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .win_valid_i (win_valid),
        .win_beat_i  (win_beat),
        .credit_i    (credit_i),
        .meta_push_o (meta_push),
        .meta_o      (meta_in),
        .bin_valid_o (bin_valid),
        .bin_o       (bin),
        .bin_idx_o   (bin_idx),
        .overflow_o  (overflow_o)
    );

    // frame info of accepted symbols, in DFT order
    meta_fifo #(
        .DEPTH (`DEMOD_META_DEPTH)
    ) u_meta_fifo (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .push_i      (meta_push),
        .push_data_i (meta_in),
        .pop_i       (meta_pop),
        .head_o      (meta_head),
        .empty_o     (meta_empty)
    );

    phase_rotator u_phase_rotator (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .bin_valid_i (bin_valid),
        .bin_i       (bin),
        .bin_idx_i   (bin_idx),
        .meta_head_i (meta_head),
        .meta_pop_o  (meta_pop),
        .out_valid_o (out_valid_o),
        .out_beat_o  (out_beat_o)
    );

    // every bin leaving the DFT has its symbol's frame info waiting
    a_meta_ready: assert property (@(posedge clk_i) disable iff (!reset_ni)
        bin_valid |-> !meta_empty);

endmodule

//--- tb/demod_checker.sv
`timescale 1ns/1ps
`include "demod_params.svh"

module demod_checker (
    input logic                 clk_i,
    input logic                 reset_ni,
    input logic                 out_valid_i,
    input demod_pkg::out_beat_t out_beat_i,
    input logic                 overflow_i,
    input logic                 credit_i,
    input logic                 ovf_allowed_i
);

    demod_pkg::out_beat_t exp_q [$];   // filled by the reference model

    int         err_cnt = 0;
    int         bin_cnt = 0;
    int         sym_cnt = 0;
    int         started = 0;            // symbols whose first bin was seen
    int         credited = 0;
    logic [2:0] credit_pipe = '0;
    logic       sym_open = 1'b0;
    logic       ovf_seen = 1'b0;

    function automatic void expect_bin(demod_pkg::out_beat_t b);
        exp_q.push_back(b);
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    always @(posedge clk_i) begin
        demod_pkg::out_beat_t exp;
        if (!reset_ni) begin
            credit_pipe = '0;
        end else begin
            // a returned credit can show up as a first bin three cycles later
            credited += int'(credit_pipe[2]);
            credit_pipe = {credit_pipe[1:0], credit_i};

            if (overflow_i && !ovf_allowed_i && !ovf_seen) begin
                compare("overflow_o", 32'd0, 32'(overflow_i));
                ovf_seen = 1'b1;
            end

            if (out_valid_i) begin
                if (!sym_open) begin
                    started++;
                    if (started > `DEMOD_CREDITS + credited) begin
                        $display("symbol started at t=%0t without a credit", $time);
                        err_cnt++;
                    end
                end
                sym_open = !out_beat_i.last;

                if (exp_q.size() == 0) begin
                    $display("unexpected output bin at t=%0t", $time);
                    err_cnt++;
                end else begin
                    exp = exp_q.pop_front();
                    compare("out_beat_o.bin.re", 32'(exp.bin.re), 32'(out_beat_i.bin.re));
                    compare("out_beat_o.bin.im", 32'(exp.bin.im), 32'(out_beat_i.bin.im));
                    compare("out_beat_o.last", 32'(exp.last), 32'(out_beat_i.last));
                    compare("out_beat_o.meta", 32'(exp.meta), 32'(out_beat_i.meta));
                end
                bin_cnt++;
                if (out_beat_i.last) sym_cnt++;
            end
        end
    end

endmodule

//--- tb/ofdm_demod_tb.sv
`timescale 1ns/1ps
`include "demod_params.svh"

module ofdm_demod_tb;

    localparam int N   = `DEMOD_FFT_LEN;
    localparam int ADV = `DEMOD_CP_ADVANCE;

    logic                 clk_i;
    logic                 reset_ni;
    logic                 in_valid_i;
    demod_pkg::sample_t   in_data_i;
    frame_pkg::in_user_t  in_user_i;
    logic                 in_last_i;
    logic                 ssb_start_i;
    logic                 credit_i;
    logic                 out_valid_o;
    demod_pkg::out_beat_t out_beat_o;
    logic                 overflow_o;

    logic [31:0] lfsr;
    int          tb_err;
    int          returned;          // credits handed back so far
    int          credit_delay_max;
    logic        credit_hold;
    logic        ovf_allowed;
    logic        drop_window;       // next window finds both buffers full
    logic        gap_en;

    // reference framing state
    int                   m_state;  // 0 cp, 1 window, 2 tail
    int                   m_cnt;
    int                   m_skip;
    frame_pkg::sym_meta_t m_meta;
    demod_pkg::sample_t   m_win [N];

    ofdm_demod UUT (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_user_i   (in_user_i),
        .in_last_i   (in_last_i),
        .ssb_start_i (ssb_start_i),
        .credit_i    (credit_i),
        .out_valid_o (out_valid_o),
        .out_beat_o  (out_beat_o),
        .overflow_o  (overflow_o)
    );

    demod_checker u_checker (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .out_valid_i   (out_valid_o),
        .out_beat_i    (out_beat_o),
        .overflow_i    (overflow_o),
        .credit_i      (credit_i),
        .ovf_allowed_i (ovf_allowed)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one LFSR step per bit
    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic int total_errors();
        return tb_err + u_checker.err_cnt;
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
            tb_err++;
        end
    endtask

    // X_k = sum x_n (-j)^(nk), then times j^(ADV k); (-j) is j^3
    task automatic queue_bins();
        demod_pkg::out_beat_t b;
        int re;
        int im;
        int a;
        int c;
        for (int k = 0; k < N; k++) begin
            re = 0;
            im = 0;
            for (int n = 0; n < N; n++) begin
                a = $signed(m_win[n].re);
                c = $signed(m_win[n].im);
                case ((3 * n * k + ADV * k) % 4)
                    0: begin
                        re += a;
                        im += c;
                    end
                    1: begin
                        re -= c;
                        im += a;
                    end
                    2: begin
                        re -= a;
                        im -= c;
                    end
                    default: begin
                        re += c;
                        im -= a;
                    end
                endcase
            end
            b.bin.re = demod_pkg::iq_out_t'(re);
            b.bin.im = demod_pkg::iq_out_t'(im);
            b.last   = k == N - 1;
            b.meta   = m_meta;
            u_checker.expect_bin(b);
        end
    endtask

    task automatic model_sample(demod_pkg::sample_t x, frame_pkg::in_user_t u,
                                logic last, logic ssb);
        if (m_state == 0 || (m_state == 2 && ssb)) begin
            if (ssb || m_cnt == 0) begin  // CP sample 1 of a new symbol
                m_meta = u.meta;
                m_skip = int'(u.cp_len) - ADV;
                m_cnt  = 0;
            end
            m_cnt++;
            if (m_cnt == m_skip) begin
                m_state = 1;
                m_cnt   = 0;
            end else begin
                m_state = 0;
            end
        end else if (m_state == 1) begin
            m_win[m_cnt] = x;
            m_cnt++;
            if (m_cnt == N) begin
                m_cnt   = 0;
                m_state = last ? 0 : 2;
                if (drop_window) drop_window = 1'b0;
                else             queue_bins();
            end
        end else if (last) begin
            m_state = 0;
        end
    endtask

    // tail counts samples after the window, limit >= 0 cuts the symbol short
    task automatic send_symbol(int cp, int tail, logic ssb, int limit,
                               frame_pkg::sym_meta_t meta);
        int                  n;
        demod_pkg::sample_t  x;
        frame_pkg::in_user_t u;
        logic                last;
        n        = (limit < 0) ? cp - ADV + N + tail : limit;
        u.meta   = meta;
        u.cp_len = frame_pkg::cp_len_t'(cp);
        for (int i = 0; i < n; i++) begin
            if (gap_en && take_bits(2) == 0) begin
                @(posedge clk_i);
                in_valid_i  <= 1'b0;
                ssb_start_i <= 1'b0;
            end
            x.re = demod_pkg::iq_in_t'(take_bits(8));
            x.im = demod_pkg::iq_in_t'(take_bits(8));
            last = limit < 0 && i == n - 1;
            @(posedge clk_i);
            in_valid_i  <= 1'b1;
            in_data_i   <= x;
            in_user_i   <= u;
            in_last_i   <= last;
            ssb_start_i <= ssb && i == 0;
            model_sample(x, u, last, ssb && i == 0);
        end
    endtask

    task automatic idle_input();
        @(posedge clk_i);
        in_valid_i  <= 1'b0;
        in_last_i   <= 1'b0;
        ssb_start_i <= 1'b0;
    endtask

    task automatic wait_pending(int max_bins);
        int t;
        t = 0;
        while (u_checker.pending() > max_bins && t < 2000) begin
            idle_input();
            t++;
        end
        if (u_checker.pending() > max_bins) begin
            $display("timeout at t=%0t while waiting for expected bins", $time);
            tb_err++;
        end
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while ((u_checker.pending() != 0 || returned != u_checker.sym_cnt || credit_i)
               && t < 3000) begin
            idle_input();
            t++;
        end
        if (t == 3000) begin
            $display("timeout at t=%0t, output or credit return never finished", $time);
            tb_err++;
        end
        repeat (3) @(posedge clk_i);
    endtask

    task automatic run_random(int count);
        for (int i = 0; i < count; i++) begin
            wait_pending(N);
            send_symbol(2 + take_bits(1), take_bits(2) % 3, 1'b0, -1,
                        frame_pkg::sym_meta_t'(take_bits(19)));
        end
        idle_input();
        wait_drained();
    endtask

    task automatic close_test(string name, int err_before);
        int errs;
        errs = total_errors() - err_before;
        if (errs == 0) $display("test %s: ok", name);
        else           $display("test %s: %0d errors", name, errs);
    endtask

    // downstream hands back one credit per received symbol
    initial begin
        int d;
        credit_i = 1'b0;
        returned = 0;
        forever begin
            @(posedge clk_i);
            credit_i <= 1'b0;
            if (!credit_hold && returned < u_checker.sym_cnt) begin
                d = take_bits(4) % (credit_delay_max + 1);
                repeat (d) @(posedge clk_i);
                credit_i <= 1'b1;
                returned++;
            end
        end
    end

    initial begin
        int                   e;
        int                   t;
        frame_pkg::sym_meta_t meta;
        lfsr             = 32'd92764;
        clk_i            = 1'b0;
        reset_ni         = 1'b0;
        in_valid_i       = 1'b0;
        in_data_i        = '0;
        in_user_i        = '0;
        in_last_i        = 1'b0;
        ssb_start_i      = 1'b0;
        tb_err           = 0;
        credit_delay_max = 0;
        credit_hold      = 1'b0;
        ovf_allowed      = 1'b0;
        drop_window      = 1'b0;
        gap_en           = 1'b0;
        m_state          = 0;
        m_cnt            = 0;
        m_skip           = 1;
        m_meta           = '0;
        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;

        e = total_errors();
        repeat (4) begin
            @(posedge clk_i);
            check_value("out_valid_o", 0, out_valid_o);
            check_value("overflow_o", 0, overflow_o);
        end
        close_test("reset_state", e);

        e = total_errors();
        run_random(24);
        close_test("back_to_back", e);

        e = total_errors();
        for (int i = 0; i < 6; i++) begin
            meta.sfn      = frame_pkg::sfn_t'(1000 + i);
            meta.subframe = frame_pkg::subframe_t'(3 * i);
            meta.symbol   = frame_pkg::symbol_t'(13 - i);
            wait_pending(N);
            send_symbol(2 + i % 2, i % 3, 1'b0, -1, meta);
        end
        idle_input();
        wait_drained();
        close_test("frame_metadata", e);

        e = total_errors();
        gap_en           = 1'b1;
        credit_delay_max = 15;
        run_random(24);
        check_value("overflow_o", 0, overflow_o);
        close_test("credit_delay", e);

        e = total_errors();
        credit_delay_max = 0;
        send_symbol(2, 2, 1'b0, 2 - ADV + N + 1, frame_pkg::sym_meta_t'(take_bits(19)));
        send_symbol(3, 1, 1'b1, -1, frame_pkg::sym_meta_t'(take_bits(19)));   // ssb in the tail
        wait_pending(N);
        send_symbol(3, 0, 1'b0, 1, frame_pkg::sym_meta_t'(take_bits(19)));
        send_symbol(2, 1, 1'b1, -1, frame_pkg::sym_meta_t'(take_bits(19)));   // ssb in the CP
        wait_pending(N);
        send_symbol(3, 1, 1'b0, -1, frame_pkg::sym_meta_t'(take_bits(19)));
        idle_input();
        wait_drained();
        check_value("overflow_o", 0, overflow_o);
        close_test("ssb_realign", e);

        // spend both credits, then fill both buffers and one more
        e = total_errors();
        credit_hold = 1'b1;
        run_random(0);
        send_symbol(2, 1, 1'b0, -1, frame_pkg::sym_meta_t'(take_bits(19)));
        send_symbol(3, 0, 1'b0, -1, frame_pkg::sym_meta_t'(take_bits(19)));
        wait_pending(0);
        ovf_allowed = 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (i == 2) drop_window = 1'b1;
            send_symbol(2 + take_bits(1), take_bits(2) % 3, 1'b0, -1,
                        frame_pkg::sym_meta_t'(take_bits(19)));
        end
        idle_input();
        t = 0;
        while (!overflow_o && t < 100) begin
            @(posedge clk_i);
            t++;
        end
        check_value("overflow_o", 1, overflow_o);
        check_value("bins held back", 2 * N, u_checker.pending());
        credit_hold = 1'b0;
        wait_drained();
        check_value("overflow_o", 1, overflow_o);
        close_test("overflow", e);

        $display("summary: %0d bins, %0d symbols, %0d errors",
                 u_checker.bin_cnt, u_checker.sym_cnt, total_errors());
        if (total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- ofdm_demod.f
+incdir+logic
logic/frame_pkg.sv
logic/demod_pkg.sv
logic/cp_remover.sv
logic/meta_fifo.sv
logic/block_dft4.sv
logic/phase_rotator.sv
logic/ofdm_demod.sv
tb/demod_checker.sv
tb/ofdm_demod_tb.sv

//--- Makefile
SRCS := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vofdm_demod_tb: $(SRCS) ofdm_demod.f
	verilator --binary --timing --assert -Wno-fatal --top-module ofdm_demod_tb -f ofdm_demod.f

run: obj_dir/Vofdm_demod_tb
	./obj_dir/Vofdm_demod_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
